// File: src.f
hdl/bus_pkg.sv
hdl/mem_pkg.sv
hdl/cache_bus_controller.sv
hdl/bus_arbiter.sv
hdl/mem_bus_slave.sv
hdl/bus_subsystem.sv
bench/tb_bus_subsystem.sv

// File: Makefile
# Verilator build and run for the bus subsystem testbench

TOP = tb_bus_subsystem

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f src.f

# pass or fail comes from the log, not from the simulator exit code
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASSED" sim.log

lint:
	verilator --lint-only --top-module bus_subsystem hdl/bus_pkg.sv hdl/mem_pkg.sv \
		hdl/cache_bus_controller.sv hdl/bus_arbiter.sv hdl/mem_bus_slave.sv hdl/bus_subsystem.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: bench/tb_bus_subsystem.sv
// bus_subsystem testbench with clock, reset, xorshift data, directed transfer tests and watchdog
`timescale 1ns/1ns
module tb_bus_subsystem;

   // writes and reads issued by all tests together
   localparam int n_transfers = 42;

   logic                           bus_clk;
   logic                           rst_n;
   logic                           mod0_en, mod0_wr, mod0_r;
   logic                           mod1_en, mod1_wr, mod1_r;
   logic [bus_pkg::bus_addr_w-1:0] mod0_a, mod1_a;
   logic [bus_pkg::line_w-1:0]     mod0_write_data, mod0_read_data;
   logic [bus_pkg::line_w-1:0]     mod1_write_data, mod1_read_data;

   // expected memory, same line index as the slave
   logic [bus_pkg::line_w-1:0] ref_mem [mem_pkg::mem_lines];
   logic [31:0]                rng = 32'h1ef8_7565;
   int                         checks = 0;
   int                         errors = 0;

   bus_subsystem dut0 (.*);

   always #4 bus_clk = ~bus_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // four random words, word k lands in bits 32k+31:32k
   task automatic make_line(output logic [bus_pkg::line_w-1:0] line);
      for (int k = 0; k < bus_pkg::beats_per_line; k++) begin
         rng = xorshift(rng);
         line[k*bus_pkg::bus_data_w +: bus_pkg::bus_data_w] = rng;
      end
   endtask

   // one ready pulse per request, none for an idle unit, read data against ref_mem
   task automatic check_unit(input string name, input int unit, input logic used,
                             input logic wr, input logic [bus_pkg::line_w-1:0] exp,
                             input int cnt, input logic [bus_pkg::line_w-1:0] got);
      checks++;
      assert (!used || cnt != 0) else begin
         errors++;
         $display("%s: unit %0d never raised its ready pulse", name, unit);
      end
      if (!used || cnt != 0) begin
         assert (cnt == int'(used)) else begin
            errors++;
            $display("Fail %s: unit %0d ready pulses expected %0d, actual %0d",
                     name, unit, int'(used), cnt);
         end
      end
      if (used && !wr && cnt == 1) begin
         checks++;
         assert (got == exp) else begin
            errors++;
            $display("Fail %s: unit %0d expected %h, actual %h", name, unit, exp, got);
         end
      end
   endtask

   // start a transfer on one or both units, drop each enable after its mod_r
   task automatic run_pair(input string name,
                           input logic use0, input logic wr0,
                           input logic [bus_pkg::bus_addr_w-1:0] a0,
                           input logic [bus_pkg::line_w-1:0] d0,
                           input logic use1, input logic wr1,
                           input logic [bus_pkg::bus_addr_w-1:0] a1,
                           input logic [bus_pkg::line_w-1:0] d1);
      int cnt0;
      int cnt1;
      int n;
      cnt0 = 0;
      cnt1 = 0;
      n = 0;
      @(posedge bus_clk);
      #1;
      if (use0) begin
         mod0_wr = wr0;
         mod0_a = a0;
         mod0_write_data = d0;
         mod0_en = 1'b1;
         if (wr0) ref_mem[a0[11:4]] = d0;
      end
      if (use1) begin
         mod1_wr = wr1;
         mod1_a = a1;
         mod1_write_data = d1;
         mod1_en = 1'b1;
         if (wr1) ref_mem[a1[11:4]] = d1;
      end
      // sample at the falling edge, away from the registered outputs
      while (((use0 && cnt0 == 0) || (use1 && cnt1 == 0)) && n < 100) begin
         @(negedge bus_clk);
         if (mod0_r) cnt0++;
         if (mod1_r) cnt1++;
         @(posedge bus_clk);
         #1;
         if (cnt0 != 0) mod0_en = 1'b0;
         if (cnt1 != 0) mod1_en = 1'b0;
         n++;
      end
      mod0_en = 1'b0;
      mod1_en = 1'b0;
      // a repeated pulse would show up here
      repeat (4) begin
         @(negedge bus_clk);
         if (mod0_r) cnt0++;
         if (mod1_r) cnt1++;
      end
      check_unit(name, 0, use0, wr0, ref_mem[a0[11:4]], cnt0, mod0_read_data);
      check_unit(name, 1, use1, wr1, ref_mem[a1[11:4]], cnt1, mod1_read_data);
   endtask

   // no ready pulse during reset or while both enables are low
   // both controllers sit in bus_pkg::st_idle here with br and mod_r low
   task automatic reset_quiet();
      int pulses;
      pulses = 0;
      rst_n = 1'b0;
      // eight rising edges with rst_n low
      repeat (8) begin
         @(posedge bus_clk);
         #1;
         if (mod0_r || mod1_r) pulses++;
      end
      rst_n = 1'b1;
      repeat (6) begin
         @(negedge bus_clk);
         if (mod0_r || mod1_r) pulses++;
      end
      checks++;
      assert (pulses == 0) else begin
         errors++;
         $display("reset_quiet: a ready pulse appeared with no enable raised");
      end
   endtask

   task automatic write_then_read();
      logic [bus_pkg::line_w-1:0] line;
      make_line(line);
      run_pair("write_then_read", 1'b1, 1'b1, 16'h0120, line, 1'b0, 1'b0, '0, '0);
      run_pair("write_then_read", 1'b1, 1'b0, 16'h0120, '0, 1'b0, 1'b0, '0, '0);
   endtask

   // bits 3:0 differ, same line
   task automatic cross_unit_read();
      logic [bus_pkg::line_w-1:0] line;
      make_line(line);
      run_pair("cross_unit_read", 1'b1, 1'b1, 16'h1230, line, 1'b0, 1'b0, '0, '0);
      run_pair("cross_unit_read", 1'b0, 1'b0, '0, '0, 1'b1, 1'b0, 16'h123c, '0);
   endtask

   // both enables rise in the same cycle, completion order left open
   task automatic contention();
      logic [bus_pkg::line_w-1:0] line0;
      logic [bus_pkg::line_w-1:0] line1;
      make_line(line0);
      make_line(line1);
      run_pair("contention", 1'b1, 1'b1, 16'h0400, line0, 1'b1, 1'b1, 16'h0810, line1);
      run_pair("contention", 1'b1, 1'b0, 16'h0400, '0, 1'b1, 1'b0, 16'h0810, '0);
   endtask

   // mask keeps a held enable from starting a second write
   task automatic held_enable();
      logic [bus_pkg::line_w-1:0] line;
      int n;
      int extra;
      n = 0;
      extra = 0;
      make_line(line);
      @(posedge bus_clk);
      #1;
      mod0_wr = 1'b1;
      mod0_a = 16'h0a50;
      mod0_write_data = line;
      mod0_en = 1'b1;
      ref_mem[8'ha5] = line;
      while (!mod0_r && n < 100) begin
         @(negedge bus_clk);
         n++;
      end
      checks++;
      assert (mod0_r) else begin
         errors++;
         $display("held_enable: unit 0 never raised its ready pulse");
      end
      repeat (20) begin
         @(negedge bus_clk);
         if (mod0_r) extra++;
      end
      checks++;
      assert (extra == 0) else begin
         errors++;
         $display("Fail held_enable: extra ready pulses expected 0, actual %0d", extra);
      end
      // one low cycle before the next request
      @(posedge bus_clk);
      #1;
      mod0_en = 1'b0;
      run_pair("held_enable", 1'b1, 1'b0, 16'h0a50, '0, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic random_sweep();
      logic [bus_pkg::bus_addr_w-1:0] addrs [16];
      logic [bus_pkg::line_w-1:0]     line;
      logic                           sel;
      for (int i = 0; i < 16; i++) begin
         rng = xorshift(rng);
         addrs[i] = rng[15:0];
         make_line(line);
         sel = (i % 2 == 0);
         run_pair("random_sweep", sel, 1'b1, addrs[i], line, !sel, 1'b1, addrs[i], line);
      end
      // read back from the other unit
      for (int i = 0; i < 16; i++) begin
         sel = (i % 2 == 1);
         run_pair("random_sweep", sel, 1'b0, addrs[i], '0, !sel, 1'b0, addrs[i], '0);
      end
   endtask

   initial begin
      bus_clk = 1'b0;
      rst_n = 1'b0;
      mod0_en = 1'b0;
      mod0_wr = 1'b0;
      mod0_a = '0;
      mod0_write_data = '0;
      mod1_en = 1'b0;
      mod1_wr = 1'b0;
      mod1_a = '0;
      mod1_write_data = '0;
      reset_quiet();
      write_then_read();
      cross_unit_read();
      contention();
      held_enable();
      random_sweep();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // 40 cycles per transfer plus the reset time
   initial begin
      #(n_transfers * 40 * 8 + 8 * 8);
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: hdl/bus_subsystem.sv
// two cache bus controllers, round-robin arbiter and line memory slave
`timescale 1ns/1ns
module bus_subsystem (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   // instruction-side unit
   input  logic                          mod0_en,
   input  logic                          mod0_wr,
   input  logic [bus_pkg::bus_addr_w-1:0] mod0_a,
   input  logic [bus_pkg::line_w-1:0]    mod0_write_data,
   output logic [bus_pkg::line_w-1:0]    mod0_read_data,
   output logic                          mod0_r,
   // data-side unit
   input  logic                          mod1_en,
   input  logic                          mod1_wr,
   input  logic [bus_pkg::bus_addr_w-1:0] mod1_a,
   input  logic [bus_pkg::line_w-1:0]    mod1_write_data,
   output logic [bus_pkg::line_w-1:0]    mod1_read_data,
   output logic                          mod1_r
);

   // per-master request side
   logic                           br0, br1, bg0, bg1;
   logic                           start0, start1, rw0, rw1;
   logic [bus_pkg::bus_addr_w-1:0] addr0, addr1;
   logic [bus_pkg::bus_data_w-1:0] wdata0, wdata1;
   logic                           ack0, ack1;
   // shared bus after selection
   logic                           start, rw, ack;
   logic [bus_pkg::bus_addr_w-1:0] addr;
   logic [bus_pkg::bus_data_w-1:0] wdata, rdata;

   cache_bus_controller ctrl0 (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .mod_en(mod0_en), .mod_wr(mod0_wr), .mod_a(mod0_a),
      .mod_write_data(mod0_write_data), .mod_read_data(mod0_read_data), .mod_r(mod0_r),
      .br(br0), .bg(bg0), .start(start0), .addr(addr0), .rw(rw0),
      .wdata(wdata0), .rdata(rdata), .ack_in(ack0)
   );

   cache_bus_controller ctrl1 (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .mod_en(mod1_en), .mod_wr(mod1_wr), .mod_a(mod1_a),
      .mod_write_data(mod1_write_data), .mod_read_data(mod1_read_data), .mod_r(mod1_r),
      .br(br1), .bg(bg1), .start(start1), .addr(addr1), .rw(rw1),
      .wdata(wdata1), .rdata(rdata), .ack_in(ack1)
   );

   bus_arbiter arb0 (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .br0(br0), .br1(br1), .bg0(bg0), .bg1(bg1),
      .start0(start0), .start1(start1), .addr0(addr0), .addr1(addr1),
      .rw0(rw0), .rw1(rw1), .wdata0(wdata0), .wdata1(wdata1),
      .start(start), .addr(addr), .rw(rw), .wdata(wdata),
      .ack(ack), .ack0(ack0), .ack1(ack1)
   );

   // read data fans out to both masters, only the acked one samples it
   mem_bus_slave mem0 (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .start(start), .addr(addr), .rw(rw),
      .wdata(wdata), .rdata(rdata), .ack(ack)
   );

endmodule

// File: hdl/mem_bus_slave.sv
// line memory answering four-beat reads and writes with paced per-beat acks
`timescale 1ns/1ns
module mem_bus_slave (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   input  logic                          start,
   input  logic [bus_pkg::bus_addr_w-1:0] addr,
   input  logic                          rw,
   input  logic [bus_pkg::bus_data_w-1:0] wdata,
   output logic [bus_pkg::bus_data_w-1:0] rdata,
   output logic                          ack
);

   // one word per beat, lines aligned so address bits 3:0 play no part
   logic [bus_pkg::bus_data_w-1:0] mem [mem_pkg::mem_lines][bus_pkg::beats_per_line];

   logic                            active;
   logic                            wr_q;
   logic [mem_pkg::mem_index_w-1:0] idx;
   logic [bus_pkg::beat_cnt_w-1:0]  beat;
   logic [mem_pkg::mem_wait_w-1:0]  wait_cnt;
   logic                            last_beat;

   // ack once the wait count runs out
   assign ack = active && (wait_cnt == mem_pkg::mem_wait_w'(mem_pkg::mem_wait_cycles));

   assign last_beat = (beat == bus_pkg::beat_cnt_w'(bus_pkg::beats_per_line - 1));

   // read word of the latched line, sampled by the master in the ack cycle
   assign rdata = mem[idx][beat];

   // transfer pacing
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         active   <= 1'b0;
         wait_cnt <= '0;
         beat     <= '0;
      end else if (!active) begin
         if (start) begin
            active   <= 1'b1;
            wait_cnt <= '0;
            beat     <= '0;
         end
      end else if (ack) begin
         // next beat waits again
         wait_cnt <= '0;
         beat     <= beat + 1'b1;
         if (last_beat) begin
            active <= 1'b0;
         end
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // line index and direction captured with start
   // bits 15:12 fold onto the same 256 lines
   always_ff @(posedge bus_clk) begin
      if (!active && start) begin
         idx  <= addr[11:4];
         wr_q <= rw;
      end
   end

   // write beat lands in the ack cycle
   always_ff @(posedge bus_clk) begin
      if (ack && wr_q) begin
         mem[idx][beat] <= wdata;
      end
   end

endmodule

// File: hdl/bus_arbiter.sv
// two-master round-robin grant and shared-bus selection toward the slave
`timescale 1ns/1ns
module bus_arbiter (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   input  logic                          br0,
   input  logic                          br1,
   output logic                          bg0,
   output logic                          bg1,
   input  logic                          start0,
   input  logic                          start1,
   input  logic [bus_pkg::bus_addr_w-1:0] addr0,
   input  logic [bus_pkg::bus_addr_w-1:0] addr1,
   input  logic                          rw0,
   input  logic                          rw1,
   input  logic [bus_pkg::bus_data_w-1:0] wdata0,
   input  logic [bus_pkg::bus_data_w-1:0] wdata1,
   output logic                          start,
   output logic [bus_pkg::bus_addr_w-1:0] addr,
   output logic                          rw,
   output logic [bus_pkg::bus_data_w-1:0] wdata,
   input  logic                          ack,
   output logic                          ack0,
   output logic                          ack1
);

   // set when master 1 took the most recent grant
   logic last1;
   logic bus_free;

   assign bus_free = !bg0 && !bg1;

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         bg0   <= 1'b0;
         bg1   <= 1'b0;
         last1 <= 1'b0;
      end else if (bus_free) begin
         // tie goes to whoever did not win last time
         if (br0 && (!br1 || last1)) begin
            bg0   <= 1'b1;
            last1 <= 1'b0;
         end else if (br1) begin
            bg1   <= 1'b1;
            last1 <= 1'b1;
         end
      end else begin
         // grant held until its owner drops br
         if (bg0 && !br0) begin
            bg0 <= 1'b0;
         end
         if (bg1 && !br1) begin
            bg1 <= 1'b0;
         end
      end
   end

   // only the granted master reaches the slave
   always_comb begin
      start = 1'b0;
      addr  = '0;
      rw    = 1'b0;
      wdata = '0;
      if (bg0) begin
         start = start0;
         addr  = addr0;
         rw    = rw0;
         wdata = wdata0;
      end else if (bg1) begin
         start = start1;
         addr  = addr1;
         rw    = rw1;
         wdata = wdata1;
      end
   end

   // acks go back to the owner only
   assign ack0 = ack && bg0;
   assign ack1 = ack && bg1;

endmodule

// File: hdl/cache_bus_controller.sv
// bus master with request mask, beat counter, line buffer and ready pulse
`timescale 1ns/1ns
module cache_bus_controller (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   // work unit side
   input  logic                          mod_en,
   input  logic                          mod_wr,
   input  logic [bus_pkg::bus_addr_w-1:0] mod_a,
   input  logic [bus_pkg::line_w-1:0]    mod_write_data,
   output logic [bus_pkg::line_w-1:0]    mod_read_data,
   output logic                          mod_r,
   // arbiter side
   output logic                          br,
   input  logic                          bg,
   // slave side, routed through the arbiter
   output logic                          start,
   output logic [bus_pkg::bus_addr_w-1:0] addr,
   output logic                          rw,
   output logic [bus_pkg::bus_data_w-1:0] wdata,
   input  logic [bus_pkg::bus_data_w-1:0] rdata,
   input  logic                          ack_in
);

   logic [bus_pkg::state_w-1:0]    state;
   logic [bus_pkg::state_w-1:0]    next_state;
   logic [bus_pkg::beat_cnt_w-1:0] beat;
   logic [bus_pkg::line_w-1:0]     line_buf;
   logic                           mask;
   logic                           masked_en;
   logic                           in_xfer;
   logic                           last_beat;
   logic                           done;
   logic                           ready_q;

   // a finished request stays masked until the unit lets go of mod_en
   assign masked_en = mod_en && !mask;

   // data phase, either direction
   assign in_xfer = (state == bus_pkg::st_wr) || (state == bus_pkg::st_rd);

   assign last_beat = (beat == bus_pkg::beat_cnt_w'(bus_pkg::beats_per_line - 1));

   // fourth ack of the line
   assign done = in_xfer && ack_in && last_beat;

   // next state
   always_comb begin
      next_state = state;
      case (state)
         bus_pkg::st_idle: begin
            if (masked_en) begin
               next_state = bus_pkg::st_br;
            end
         end
         bus_pkg::st_br: begin
            // stay here as long as another master owns the bus
            if (bg) begin
               next_state = bus_pkg::st_mstr;
            end
         end
         bus_pkg::st_mstr: begin
            next_state = mod_wr ? bus_pkg::st_wr : bus_pkg::st_rd;
         end
         bus_pkg::st_wr, bus_pkg::st_rd: begin
            if (done) begin
               next_state = bus_pkg::st_idle;
            end
         end
         default: begin
            next_state = bus_pkg::st_idle;
         end
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         state <= bus_pkg::st_idle;
      end else begin
         state <= next_state;
      end
   end

   // request mask
   // completion wins over a same-cycle clear
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         mask <= 1'b0;
      end else if (done) begin
         mask <= 1'b1;
      end else if (!mod_en || state == bus_pkg::st_mstr) begin
         mask <= 1'b0;
      end
   end

   // beat index, restarted in the address phase and stepped on every ack
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         beat <= '0;
      end else if (state == bus_pkg::st_mstr) begin
         beat <= '0;
      end else if (in_xfer && ack_in) begin
         beat <= beat + 1'b1;
      end
   end

   // line buffer, one word per read ack
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         line_buf <= '0;
      end else if (state == bus_pkg::st_rd && ack_in) begin
         line_buf[beat*bus_pkg::bus_data_w +: bus_pkg::bus_data_w] <= rdata;
      end
   end

   // ready pulse, the cycle after the last ack
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= done;
      end
   end

   assign mod_read_data = line_buf;
   assign mod_r         = ready_q;

   // request held from st_br until the state machine drops back to idle
   assign br    = (state != bus_pkg::st_idle);
   assign start = (state == bus_pkg::st_mstr);
   assign addr  = mod_a;
   assign rw    = mod_wr;
   // outgoing word follows the beat index, low word first
   assign wdata = mod_write_data[beat*bus_pkg::bus_data_w +: bus_pkg::bus_data_w];

endmodule

// File: hdl/mem_pkg.sv
// memory geometry and slave beat pacing for the line memory
package mem_pkg;

   // lines held by the slave, indexed by address bits 11:4
   localparam int mem_lines = 256;

   // line index width
   localparam int mem_index_w = 8;

   // idle cycles ahead of each beat's ack
   localparam int mem_wait_cycles = 1;

   // wait counter must reach mem_wait_cycles
   localparam int mem_wait_w = (mem_wait_cycles > 0) ? $clog2(mem_wait_cycles + 1) : 1;

endpackage

// File: hdl/bus_pkg.sv
// bus widths, line geometry, beat count and one-hot controller state encoding
package bus_pkg;

   // one beat on the shared data bus
   localparam int bus_data_w = 32;

   // byte address sent by the master in its address phase
   localparam int bus_addr_w = 16;

   // a cache line is what a work unit reads or writes in one transfer
   localparam int line_w = 128;

   // low word goes first, so beat i carries bits 32i+31:32i
   localparam int beats_per_line = line_w / bus_data_w;

   // enough to index every beat of a line
   localparam int beat_cnt_w = 2;

   // controller state vector width
   localparam int state_w = 5;

   // one-hot controller states
   // idle waits for an unmasked enable
   localparam logic [state_w-1:0] st_idle = 5'b0_0001;
   // bus request raised, waiting for grant
   localparam logic [state_w-1:0] st_br = 5'b0_0010;
   // address phase, start pulses here
   localparam logic [state_w-1:0] st_mstr = 5'b0_0100;
   // sending write beats
   localparam logic [state_w-1:0] st_wr = 5'b0_1000;
   // collecting read beats
   localparam logic [state_w-1:0] st_rd = 5'b1_0000;

endpackage
